//--- project.f
+incdir+include
source/board_pkg.sv
source/board_input_sync.sv
source/board_control.sv
source/core_reset_gen.sv
source/player_mapper.sv
source/board_ctrl_top.sv
dv/board_ctrl_props.sv
dv/board_ctrl_tb.sv

//--- Bender.yml
package:
  name: board_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/board_pkg.sv
      - source/board_input_sync.sv
      - source/board_control.sv
      - source/core_reset_gen.sv
      - source/player_mapper.sv
      - source/board_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/board_ctrl_props.sv
      - dv/board_ctrl_tb.sv

//--- dv/board_ctrl_tb.sv
// Testbench for board_ctrl_top
// Random mapping check against a reference function followed by directed
// pause, layer enable, reset and core reset stretch tests

`timescale 1ns/1ps
`include "board_defines.svh"

module board_ctrl_tb
    import board_pkg::*;
();

    localparam int CLK_PERIOD  = 4;
    localparam int RAND_CYCLES = 400;
    localparam int TEST_CYCLES = 2400;   // Sum of all phases rounded up
    localparam int MARGIN_NS   = 800;

    logic         clk_sys;
    logic         game_rst;
    joy_t         board_joystick1, board_joystick2;
    joy_t         key_joy1, key_joy2;
    player_pair_t key_coin, key_start;
    logic         key_service, key_pause, key_reset;
    gfx_en_t      key_gfx;
    logic         rot_control, rst_req, downloading, dip_flip;
    joy_t         game_joystick1, game_joystick2;
    player_pair_t game_coin, game_start;
    logic         game_service, game_pause, core_rst;
    gfx_en_t      gfx_en;

    int errors = 0;
    int checks = 0;
    logic cmp_active = 1'b0;

    // One entry per driven cycle of the random phase
    joy_t         h_j1[$], h_j2[$], h_k1[$], h_k2[$];
    player_pair_t h_kc[$], h_ks[$];
    logic         h_ksv[$], h_rot[$];

    board_ctrl_top dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Expected {joystick1, joystick2, coin, start, service}
    function automatic logic [24:0] map_ref(input joy_t j1, input joy_t j2, input joy_t k1,
                                            input joy_t k2, input player_pair_t kc,
                                            input player_pair_t ks, input logic ksv,
                                            input logic rot);
        joy_t         m1, m2, o1, o2;
        player_pair_t coin, start;
        logic [24:0]  res;
        m1 = j1 | k1;
        m2 = j2 | k2;
        o1 = m1;
        o2 = m2;
        if (rot) begin   // Directions swapped for a vertical screen
            o1[3] = m1[0];
            o1[2] = m1[1];
            o1[1] = m1[3];
            o1[0] = m1[2];
            o2[3] = m2[0];
            o2[2] = m2[1];
            o2[1] = m2[3];
            o2[0] = m2[2];
        end
        coin[0]  = j1[`BOARD_COIN_BIT] | kc[0];
        coin[1]  = j2[`BOARD_COIN_BIT] | kc[1];
        start[0] = j1[`BOARD_START_BIT] | ks[0];
        start[1] = j2[`BOARD_START_BIT] | ks[1];
        res = {o1, o2, coin, start, ksv};
        if (`BOARD_INPUTS_ACTIVE_LOW)
            res = ~res;
        return res;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Next drive slot 1 ns after the rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk_sys);
        #1;
    endtask

    task automatic clear_inputs();
        board_joystick1 = '0;
        board_joystick2 = '0;
        key_joy1        = '0;
        key_joy2        = '0;
        key_coin        = '0;
        key_start       = '0;
        key_service     = 1'b0;
        key_pause       = 1'b0;
        key_reset       = 1'b0;
        key_gfx         = '0;
        rot_control     = 1'b0;
        rst_req         = 1'b0;
        downloading     = 1'b0;
    endtask

    task automatic drive_random();
        board_joystick1 = joy_t'($urandom);
        board_joystick2 = joy_t'($urandom);
        key_joy1        = joy_t'($urandom);
        key_joy2        = joy_t'($urandom);
        key_coin        = player_pair_t'($urandom);
        key_start       = player_pair_t'($urandom);
        key_service     = 1'($urandom);
        rot_control     = 1'($urandom);
        h_j1.push_back(board_joystick1);
        h_j2.push_back(board_joystick2);
        h_k1.push_back(key_joy1);
        h_k2.push_back(key_joy2);
        h_kc.push_back(key_coin);
        h_ks.push_back(key_start);
        h_ksv.push_back(key_service);
        h_rot.push_back(rot_control);
    endtask

    // Reset values with idle inputs
    task automatic check_idle();
        check_val("game_pause", game_pause, 0);
        check_val("gfx_en", gfx_en, {`BOARD_GFX_N{1'b1}});
        check_val("game_joystick1", game_joystick1, {`BOARD_JOY_W{1'b1}});
        check_val("game_joystick2", game_joystick2, {`BOARD_JOY_W{1'b1}});
        check_val("game_coin", game_coin, 2'b11);
        check_val("game_start", game_start, 2'b11);
        check_val("game_service", game_service, 1);
    endtask

    // Called at the slot right after the last cause edge
    task automatic check_stretch();
        check_val("core_rst", core_rst, 1);
        step(255);
        check_val("core_rst", core_rst, 1);
        step(1);
        check_val("core_rst", core_rst, 0);
    endtask

    task automatic wait_core_release();
        int cnt;
        cnt = 0;
        while (core_rst && cnt < 400) begin
            step(1);
            cnt++;
        end
        if (core_rst) begin
            errors++;
            $display("core_rst was never released after reset");
        end
    endtask

    // Outputs at the falling edge belong to the last rising edge
    always @(negedge clk_sys) begin
        int n;
        logic [24:0] exp;
        n = h_j1.size();
        if (cmp_active && n >= 3) begin
            // rot_control skips the input register
            exp = map_ref(h_j1[n-3], h_j2[n-3], h_k1[n-3], h_k2[n-3],
                          h_kc[n-3], h_ks[n-3], h_ksv[n-3], h_rot[n-2]);
            check_val("game_joystick1", game_joystick1, exp[24:15]);
            check_val("game_joystick2", game_joystick2, exp[14:5]);
            check_val("game_coin", game_coin, exp[4:3]);
            check_val("game_start", game_start, exp[2:1]);
            check_val("game_service", game_service, exp[0]);
        end
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic p;
        gfx_en_t g;
        void'($urandom(32'hcab1));
        clear_inputs();
        dip_flip = 1'b0;
        game_rst = 1'b1;
        repeat (5) @(posedge clk_sys);
        #1;
        game_rst = 1'b0;
        check_idle();

        // Random mapping
        cmp_active = 1'b1;
        repeat (RAND_CYCLES) begin
            drive_random();
            step(1);
        end
        cmp_active = 1'b0;
        clear_inputs();
        step(4);

        // Pause from the key and then from each joystick
        p = game_pause;
        key_pause = 1'b1;
        step(2);
        check_val("game_pause", game_pause, p);
        step(1);
        check_val("game_pause", game_pause, !p);
        step(5);
        check_val("game_pause", game_pause, !p);   // Held key
        key_pause = 1'b0;
        step(4);
        board_joystick1[`BOARD_PAUSE_BIT] = 1'b1;
        step(3);
        check_val("game_pause", game_pause, p);
        step(4);
        board_joystick1 = '0;
        step(4);
        board_joystick2[`BOARD_PAUSE_BIT] = 1'b1;
        step(3);
        check_val("game_pause", game_pause, !p);
        board_joystick2 = '0;
        step(4);

        // Layer enables
        for (int b = 0; b < `BOARD_GFX_N; b++) begin
            g = gfx_en;
            key_gfx = gfx_en_t'(1 << b);
            step(2);
            check_val("gfx_en", gfx_en, g);
            step(1);
            check_val("gfx_en", gfx_en, g ^ gfx_en_t'(1 << b));
            step(3);
            check_val("gfx_en", gfx_en, g ^ gfx_en_t'(1 << b));
            key_gfx = '0;
            step(3);
        end

        game_rst = 1'b1;
        step(1);
        game_rst = 1'b0;
        check_idle();
        step(3);
        check_idle();

        // Core reset causes
        wait_core_release();
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        check_stretch();

        downloading = 1'b1;
        step(3);
        downloading = 1'b0;
        check_stretch();

        dip_flip = ~dip_flip;
        step(1);
        check_stretch();

        key_reset = 1'b1;
        step(1);
        key_reset = 1'b0;
        step(2);
        check_val("core_rst", core_rst, 0);
        step(1);
        check_stretch();

        // Second request in the middle of a stretch
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        step(100);
        check_val("core_rst", core_rst, 1);
        rst_req = 1'b1;
        step(1);
        rst_req = 1'b0;
        check_stretch();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- dv/board_ctrl_props.sv
// Concurrent checks on the board control top level
// Attached to board_ctrl_top by the bind statement below

`timescale 1ns/1ps
`include "board_defines.svh"

module board_ctrl_props
    import board_pkg::*;
(
    input logic    clk_sys,
    input logic    game_rst,
    input logic    rst_req,
    input logic    downloading,
    input logic    dip_flip,
    input logic    soft_rst,
    input logic    core_rst,
    input gfx_en_t gfx_en
);

    // Flip change seen against the previous sample
    a_cause_raises_core_rst: assert property (
        @(posedge clk_sys)
        (game_rst || rst_req || downloading || soft_rst || (dip_flip != $past(dip_flip)))
            |=> core_rst
    ) else $error("core_rst low the cycle after a reset cause");

    a_soft_rst_single: assert property (@(posedge clk_sys) soft_rst |=> !soft_rst)
        else $error("soft_rst high two cycles in a row");

    a_gfx_after_reset: assert property (@(posedge clk_sys) game_rst |=> (gfx_en == '1))
        else $error("gfx_en not all ones after game_rst");

endmodule

bind board_ctrl_top board_ctrl_props u_props (
    .clk_sys     ( clk_sys     ),
    .game_rst    ( game_rst    ),
    .rst_req     ( rst_req     ),
    .downloading ( downloading ),
    .dip_flip    ( dip_flip    ),
    .soft_rst    ( soft_rst    ),
    .core_rst    ( core_rst    ),
    .gfx_en      ( gfx_en      )
);

//--- source/board_ctrl_top.sv
// Board control block top level
// Connects the input stage, user state, core reset generator and the
// game input mapper. All logic runs on clk_sys

`timescale 1ns/1ps

module board_ctrl_top
    import board_pkg::*;
(
    input  logic         clk_sys,
    input  logic         game_rst,
    // Player inputs
    input  joy_t         board_joystick1,
    input  joy_t         board_joystick2,
    input  joy_t         key_joy1,
    input  joy_t         key_joy2,
    input  player_pair_t key_coin,
    input  player_pair_t key_start,
    input  logic         key_service,
    input  logic         key_pause,
    input  logic         key_reset,
    input  gfx_en_t      key_gfx,
    input  logic         rot_control,
    // Reset causes
    input  logic         rst_req,
    input  logic         downloading,
    input  logic         dip_flip,
    // To the game core
    output joy_t         game_joystick1,
    output joy_t         game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         game_service,
    output logic         game_pause,
    output gfx_en_t      gfx_en,
    output logic         core_rst
);

    joy_t         joy1_q, joy2_q;
    joy_t         key_joy1_q, key_joy2_q;
    player_pair_t key_coin_q, key_start_q;
    logic         key_service_q;
    logic         pause_rise, reset_rise;
    gfx_en_t      gfx_rise;
    logic         soft_rst;

    board_input_sync u_input_sync (
        .clk_sys         ( clk_sys         ),
        .game_rst        ( game_rst        ),
        .board_joystick1 ( board_joystick1 ),
        .board_joystick2 ( board_joystick2 ),
        .key_joy1        ( key_joy1        ),
        .key_joy2        ( key_joy2        ),
        .key_coin        ( key_coin        ),
        .key_start       ( key_start       ),
        .key_service     ( key_service     ),
        .key_pause       ( key_pause       ),
        .key_reset       ( key_reset       ),
        .key_gfx         ( key_gfx         ),
        .joy1_q          ( joy1_q          ),
        .joy2_q          ( joy2_q          ),
        .key_joy1_q      ( key_joy1_q      ),
        .key_joy2_q      ( key_joy2_q      ),
        .key_coin_q      ( key_coin_q      ),
        .key_start_q     ( key_start_q     ),
        .key_service_q   ( key_service_q   ),
        .pause_rise      ( pause_rise      ),
        .reset_rise      ( reset_rise      ),
        .gfx_rise        ( gfx_rise        )
    );

    board_control u_control (
        .clk_sys    ( clk_sys    ),
        .game_rst   ( game_rst   ),
        .pause_rise ( pause_rise ),
        .reset_rise ( reset_rise ),
        .gfx_rise   ( gfx_rise   ),
        .game_pause ( game_pause ),
        .gfx_en     ( gfx_en     ),
        .soft_rst   ( soft_rst   )
    );

    core_reset_gen u_core_reset (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .dip_flip    ( dip_flip    ),
        .soft_rst    ( soft_rst    ),
        .core_rst    ( core_rst    )
    );

    player_mapper u_mapper (
        .clk_sys        ( clk_sys        ),
        .game_rst       ( game_rst       ),
        .joy1_q         ( joy1_q         ),
        .joy2_q         ( joy2_q         ),
        .key_joy1_q     ( key_joy1_q     ),
        .key_joy2_q     ( key_joy2_q     ),
        .key_coin_q     ( key_coin_q     ),
        .key_start_q    ( key_start_q    ),
        .key_service_q  ( key_service_q  ),
        .rot_control    ( rot_control    ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_service   ( game_service   )
    );

endmodule

//--- source/player_mapper.sv
// Output stage for the game inputs
// Merges keyboard keys into the registered joysticks, applies the rotation
// swap, converts to the game polarity and registers the result

`timescale 1ns/1ps
`include "board_defines.svh"

module player_mapper
    import board_pkg::*;
(
    input  logic         clk_sys,
    input  logic         game_rst,
    input  joy_t         joy1_q,
    input  joy_t         joy2_q,
    input  joy_t         key_joy1_q,
    input  joy_t         key_joy2_q,
    input  player_pair_t key_coin_q,
    input  player_pair_t key_start_q,
    input  logic         key_service_q,
    input  logic         rot_control,
    output joy_t         game_joystick1,
    output joy_t         game_joystick2,
    output player_pair_t game_coin,
    output player_pair_t game_start,
    output logic         game_service
);

    localparam logic         INVERT    = 1'(`BOARD_INPUTS_ACTIVE_LOW);
    localparam joy_t         JOY_MASK  = {`BOARD_JOY_W{INVERT}};
    localparam player_pair_t PAIR_MASK = {2{INVERT}};

    // Quarter turn for vertical games, buttons untouched
    function automatic joy_t rotate_joy(input joy_t joy, input logic rot);
        joy_t swapped;
        swapped = {joy[`BOARD_JOY_W-1:4], joy[0], joy[1], joy[3], joy[2]};
        return rot ? swapped : joy;
    endfunction

    joy_t         joy1_mix, joy2_mix;
    player_pair_t coin_mix, start_mix;

    assign joy1_mix  = rotate_joy(joy1_q | key_joy1_q, rot_control);
    assign joy2_mix  = rotate_joy(joy2_q | key_joy2_q, rot_control);
    // Player 2 in the upper bit
    assign coin_mix  = {joy2_q[`BOARD_COIN_BIT], joy1_q[`BOARD_COIN_BIT]} | key_coin_q;
    assign start_mix = {joy2_q[`BOARD_START_BIT], joy1_q[`BOARD_START_BIT]} | key_start_q;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_joystick1 <= JOY_MASK;     // Nothing pressed
            game_joystick2 <= JOY_MASK;
            game_coin      <= PAIR_MASK;
            game_start     <= PAIR_MASK;
            game_service   <= INVERT;
        end else begin
            game_joystick1 <= joy1_mix ^ JOY_MASK;
            game_joystick2 <= joy2_mix ^ JOY_MASK;
            game_coin      <= coin_mix ^ PAIR_MASK;
            game_start     <= start_mix ^ PAIR_MASK;
            game_service   <= key_service_q ^ INVERT;
        end
    end

endmodule

//--- source/core_reset_gen.sv
// Core reset generator
// Any cause (board reset, request, ROM download, soft reset, flip change)
// raises core_rst on the next cycle and holds it for the full stretch

`timescale 1ns/1ps

module core_reset_gen
    import board_pkg::*;
(
    input  logic clk_sys,
    input  logic game_rst,
    input  logic rst_req,
    input  logic downloading,
    input  logic dip_flip,
    input  logic soft_rst,
    output logic core_rst
);

    rst_state_t state;
    rst_cnt_t   rst_cnt;
    logic       last_flip;
    logic       restart;

    // Screen flip needs the core to start over
    always_ff @(posedge clk_sys) begin
        last_flip <= dip_flip;
    end

    assign restart = rst_req | downloading | soft_rst | (dip_flip != last_flip);

    always_ff @(posedge clk_sys) begin
        if (game_rst || restart) begin
            state   <= RST_HOLD;
            rst_cnt <= '0;        // Stretch restarts on every cause
        end else begin
            case (state)
                RST_HOLD: begin
                    if (rst_cnt == '1) begin
                        state <= RST_RUN;   // Last count, release
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                RST_RUN: begin
                    rst_cnt <= '0;
                end
                default: state <= RST_HOLD;
            endcase
        end
    end

    assign core_rst = (state == RST_HOLD);

endmodule

//--- source/board_control.sv
// User state of the board: pause toggle, graphics layer enables and the
// soft reset request. Driven by the edge pulses from board_input_sync,
// each pulse lands in its state bit one cycle later

`timescale 1ns/1ps

module board_control
    import board_pkg::*;
(
    input  logic    clk_sys,
    input  logic    game_rst,
    input  logic    pause_rise,
    input  logic    reset_rise,
    input  gfx_en_t gfx_rise,
    output logic    game_pause,
    output gfx_en_t gfx_en,
    output logic    soft_rst
);

    // Pause flips on every pulse, starts running
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_pause <= 1'b0;
        end else if (pause_rise) begin
            game_pause <= ~game_pause;
        end
    end

    // All layers shown after reset
    // Each pulse bit flips only its own layer
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            gfx_en <= '1;
        end else begin
            gfx_en <= gfx_en ^ gfx_rise;
        end
    end

    // Reset key edge becomes a single-cycle request to core_reset_gen
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= reset_rise;   // Pulse in, pulse out
        end
    end

endmodule

//--- source/board_input_sync.sv
// Input stage of the board control block
// Registers both joysticks and all decoded keys once, then builds
// one-cycle rising-edge pulses for pause, soft reset and layer keys

`timescale 1ns/1ps
`include "board_defines.svh"

module board_input_sync
    import board_pkg::*;
(
    input  logic         clk_sys,
    input  logic         game_rst,
    input  joy_t         board_joystick1,
    input  joy_t         board_joystick2,
    input  joy_t         key_joy1,
    input  joy_t         key_joy2,
    input  player_pair_t key_coin,
    input  player_pair_t key_start,
    input  logic         key_service,
    input  logic         key_pause,
    input  logic         key_reset,
    input  gfx_en_t      key_gfx,
    output joy_t         joy1_q,
    output joy_t         joy2_q,
    output joy_t         key_joy1_q,
    output joy_t         key_joy2_q,
    output player_pair_t key_coin_q,
    output player_pair_t key_start_q,
    output logic         key_service_q,
    output logic         pause_rise,
    output logic         reset_rise,
    output gfx_en_t      gfx_rise
);

    logic    key_pause_q, key_pause_d;
    logic    key_reset_q, key_reset_d;
    gfx_en_t key_gfx_q, key_gfx_d;
    logic    joy_pause, joy_pause_d;

    // Pause button on either stick, raw from the board
    assign joy_pause = joy1_q[`BOARD_PAUSE_BIT] | joy2_q[`BOARD_PAUSE_BIT];

    // Single capture stage for every player input
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            joy1_q        <= '0;
            joy2_q        <= '0;
            key_joy1_q    <= '0;
            key_joy2_q    <= '0;
            key_coin_q    <= '0;
            key_start_q   <= '0;
            key_service_q <= 1'b0;
            key_pause_q   <= 1'b0;
            key_reset_q   <= 1'b0;
            key_gfx_q     <= '0;
        end else begin
            joy1_q        <= board_joystick1;
            joy2_q        <= board_joystick2;
            key_joy1_q    <= key_joy1;
            key_joy2_q    <= key_joy2;
            key_coin_q    <= key_coin;
            key_start_q   <= key_start;
            key_service_q <= key_service;
            key_pause_q   <= key_pause;
            key_reset_q   <= key_reset;
            key_gfx_q     <= key_gfx;
        end
    end

    // Previous levels and registered edge pulses
    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            key_pause_d <= 1'b0;
            key_reset_d <= 1'b0;
            key_gfx_d   <= '0;
            joy_pause_d <= 1'b0;
            pause_rise  <= 1'b0;
            reset_rise  <= 1'b0;
            gfx_rise    <= '0;
        end else begin
            key_pause_d <= key_pause_q;
            key_reset_d <= key_reset_q;
            key_gfx_d   <= key_gfx_q;
            joy_pause_d <= joy_pause;
            pause_rise  <= (key_pause_q & ~key_pause_d) | (joy_pause & ~joy_pause_d);
            reset_rise  <= key_reset_q & ~key_reset_d;
            gfx_rise    <= key_gfx_q & ~key_gfx_d;    // Per layer
        end
    end

endmodule

//--- source/board_pkg.sv
// Shared types for the board control block
// Import into every module that carries joystick, layer or reset-counter values

`include "board_defines.svh"

package board_pkg;

    // One joystick, directions in bits 3:0, buttons above
    typedef logic [`BOARD_JOY_W-1:0] joy_t;

    // Player 1 in bit 0, player 2 in bit 1
    typedef logic [1:0] player_pair_t;

    // One enable per graphics layer
    typedef logic [`BOARD_GFX_N-1:0] gfx_en_t;

    // Core reset stretch counter
    typedef logic [`BOARD_RST_CNT_W-1:0] rst_cnt_t;

    // Core reset generator states
    typedef enum logic {
        RST_HOLD,   // core_rst asserted while the stretch counts
        RST_RUN     // Core released
    } rst_state_t;

endpackage

//--- include/board_defines.svh
// Board control block constants: widths, joystick bit map and input polarity
// Include wherever a width or bit position below is needed

`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// Widths
`define BOARD_JOY_W      10     // One joystick word
`define BOARD_GFX_N      4      // Graphics layers with a user enable
`define BOARD_RST_CNT_W  8      // Core reset stretch, 2**8 cycles

// Layout with a third fire button moves coin, start and pause up one bit
`define BOARD_THREE_BUTTONS  0

// Joystick bit positions
`define BOARD_COIN_BIT   (6 + `BOARD_THREE_BUTTONS)
`define BOARD_START_BIT  (7 + `BOARD_THREE_BUTTONS)
`define BOARD_PAUSE_BIT  (8 + `BOARD_THREE_BUTTONS)

// Game core polarity, 1 when the game expects active-low buttons
`define BOARD_INPUTS_ACTIVE_LOW  1

`endif
